/* decodeStage.f */
+incdir+include
verilog/decodePkg.sv
verilog/ctrlIf.sv
verilog/controlUnit.sv
verilog/aluOpDecode.sv
verilog/regFile.sv
verilog/pipeReg.sv
verilog/decode.sv
verilog/decodeTop.sv
tb/decodeTb.sv

/* tb/decodeTb.sv */
`timescale 1ns/100ps
`include "decode_macros.svh"

module decodeTb import decodePkg::*; ();

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 10;
   localparam int TEST_CYCLES  = 80;
   localparam int NUM_TESTS    = 6;
   // reset, register preload, all tests and the drain
   localparam int TOTAL_INSTR  = RESET_CYCLES + `REG_CNT + NUM_TESTS * TEST_CYCLES + 2;
   localparam int WATCHDOG_NS  = TOTAL_INSTR * CLK_PERIOD * 4;

   logic                  clk, arstN, stall, flush, instrValid, wbRegWrt;
   logic [`DATA_W-1:0]    instr, wbData;
   logic [`REG_SEL_W-1:0] wbReg;
   logic [`DATA_W-1:0]    exInA, exInB, exWrtData, exImm8, exImm11;
   aluOpT                 exAluOp;
   logic [`REG_SEL_W-1:0] exWrtReg;
   logic                  exRegWrt, exMemWrt, exReadEn, exImmSrc, exAluJmp, exJalSel;
   logic                  exCreateDump, exErr, exJumpInst;
   brchT                  exBrchSig;
   wbSelT                 exWbDataSel;

   logic [31:0]        rngState;
   logic [`DATA_W-1:0] shadowRegs [`REG_CNT];  // register file as the model sees it
   logic [`DATA_W-1:0] ifIdInstr;               // model of IF/ID
   logic               ifIdValid;
   idExT               idExExp;                 // model of ID/EX, expected ex outputs
   logic [4:0]         opPool [$];              // opcodes the current test draws from
   int                 checks, errors;

   decodeTop i_decodeTop (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired, the tests did not reach their end in time");
      $display("TEST FAILED");
      $finish;
   end

   // lcg, numerical recipes constants
   function automatic logic [31:0] nextRand();
      rngState = rngState * 32'd1664525 + 32'd1013904223;
      return rngState;
   endfunction

   function automatic int unsigned randBelow(input int unsigned n);
      return (nextRand() >> 8) % n;  // low bits of an lcg are weak
   endfunction

   task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   function automatic aluOpT expAluOp(input logic [4:0] opc, input logic [1:0] func);
      case (opc)
         opAddi, opSt, opLd, opStu, opJr, opJalr: return aluAdd;  // address math
         opSubi:  return aluSub;
         opXori:  return aluXor;
         opAndni: return aluAndn;
         opRoli:  return aluRol;
         opSlli:  return aluSll;
         opRori:  return aluRor;
         opSrli:  return aluSrl;
         opAluReg:   return func == 2'd0 ? aluAdd : func == 2'd1 ? aluSub :
                            func == 2'd2 ? aluXor : aluAndn;
         opShiftReg: return func == 2'd0 ? aluRol : func == 2'd1 ? aluSll :
                            func == 2'd2 ? aluRor : aluSrl;
         opSeq: return aluSeq;
         opSlt: return aluSlt;
         opSle: return aluSle;
         opSco: return aluSco;
         opBtr: return aluBtr;
         opLbi, opBeqz, opBnez, opBltz, opBgez: return aluPassB;
         opSlbi:  return aluSlbi;
         default: return aluAdd;  // halt, nop, j, jal and the gaps
      endcase
   endfunction

   // decode of one IF/ID slot against the current shadow registers
   function automatic idExT modelDecode(input logic [`DATA_W-1:0] word, input logic live);
      idExT               e;
      logic [`DATA_W-1:0] w, regB, imm5, imm8;
      logic [4:0]         opc;
      logic               zx, immAlu;
      w      = live ? word : `NOP_INSTR;  // squashed slot becomes a bubble
      opc    = w[15:11];
      immAlu = opc inside {opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli};
      zx     = opc inside {opXori, opAndni, opRoli, opSlli, opRori, opSrli, opSlbi};
      imm5   = zx ? {11'b0, w[4:0]} : {{11{w[4]}}, w[4:0]};
      imm8   = zx ? {8'b0, w[7:0]} : {{8{w[7]}}, w[7:0]};
      regB   = shadowRegs[w[7:5]];
      e = '0;
      e.aluOp   = expAluOp(opc, w[1:0]);
      e.inA     = shadowRegs[w[10:8]];
      e.inB     = (immAlu || opc inside {opSt, opLd, opStu}) ? imm5 :
                  (opc inside {opLbi, opSlbi, opJr, opJalr}) ? imm8 : regB;
      e.wrtData = (opc inside {opSt, opStu}) ? regB : e.inB;  // stores send rd
      e.imm8    = imm8;
      e.imm11   = {{5{w[10]}}, w[10:0]};
      e.wrtReg  = (immAlu || opc == opLd) ? w[7:5] :
                  (opc inside {opStu, opLbi, opSlbi}) ? w[10:8] :
                  (opc inside {opJal, opJalr}) ? 3'd7 : w[4:2];
      // 11xxx is lbi plus every R format op
      e.regWrt  = immAlu || opc[4:3] == 2'b11 || opc inside {opLd, opStu, opSlbi, opJal, opJalr};
      e.memWrt  = opc inside {opSt, opStu};
      e.wbDataSel = (opc == opLd) ? wbMem : (opc inside {opJal, opJalr}) ? wbPc2 : wbAlu;
      e.readEn  = opc == opLd;  // only a load reads memory
      case (opc)
         opBeqz:  e.brchSig = brEqz;
         opBnez:  e.brchSig = brNez;
         opBltz:  e.brchSig = brLtz;
         opBgez:  e.brchSig = brGez;
         default: e.brchSig = brNone;
      endcase
      e.immSrc     = opc inside {opJ, opJal};
      e.aluJmp     = opc inside {opJr, opJalr};
      e.jalSel     = opc inside {opJal, opJalr};
      e.createDump = opc == opHalt;
      e.err        = opc inside {5'b00010, 5'b00011};  // holes in the opcode map
      e.jumpInst   = opc inside {opJ, opJr, opJal, opJalr};
      return e;
   endfunction

   task automatic compareOutputs();
      checkVal("exAluOp", exAluOp, idExExp.aluOp);
      checkVal("exInA", exInA, idExExp.inA);
      checkVal("exInB", exInB, idExExp.inB);
      checkVal("exWrtData", exWrtData, idExExp.wrtData);
      checkVal("exImm8", exImm8, idExExp.imm8);
      checkVal("exImm11", exImm11, idExExp.imm11);
      checkVal("exWrtReg", exWrtReg, idExExp.wrtReg);  // field picked even without a write
      checkVal("exRegWrt", exRegWrt, idExExp.regWrt);
      checkVal("exMemWrt", exMemWrt, idExExp.memWrt);
      checkVal("exReadEn", exReadEn, idExExp.readEn);
      checkVal("exBrchSig", exBrchSig, idExExp.brchSig);
      checkVal("exWbDataSel", exWbDataSel, idExExp.wbDataSel);
      checkVal("exImmSrc", exImmSrc, idExExp.immSrc);
      checkVal("exAluJmp", exAluJmp, idExExp.aluJmp);
      checkVal("exJalSel", exJalSel, idExExp.jalSel);
      checkVal("exCreateDump", exCreateDump, idExExp.createDump);
      checkVal("exErr", exErr, idExExp.err);
      checkVal("exJumpInst", exJumpInst, idExExp.jumpInst);
   endtask

   // one clock, model advances on the inputs held across the edge
   task automatic stepCycle();
      @(posedge clk);
      if (!stall) begin
         idExExp   = modelDecode(ifIdInstr, ifIdValid && !flush);  // old register values
         ifIdInstr = instr;
         ifIdValid = instrValid;
      end
      if (wbRegWrt) shadowRegs[wbReg] = wbData;  // writes go on through a stall
      #1 compareOutputs();
      #1;  // caller drives the next inputs here
   endtask

   task automatic driveInputs(input int validPct, flushPct, stallPct, aliasPct);
      logic [4:0] op;
      op         = opPool[randBelow(opPool.size())];
      instr      = {op, 11'(nextRand() >> 5)};
      instrValid = randBelow(100) < validPct;
      flush      = randBelow(100) < flushPct;
      stall      = randBelow(100) < stallPct;
      wbRegWrt   = randBelow(2) == 1;
      // aim the write at the rs of the slot about to be captured
      wbReg      = (randBelow(100) < aliasPct) ? ifIdInstr[10:8] : 3'(randBelow(8));
      wbData     = 16'(nextRand() >> 3);
   endtask

   task automatic runTest(input int id, input string name,
                          input int validPct, flushPct, stallPct, aliasPct);
      int errStart;
      errStart = errors;
      for (int c = 0; c < TEST_CYCLES; c++) begin
         driveInputs(validPct, flushPct, stallPct, aliasPct);
         stepCycle();
      end
      $display("test %0d %s finished with %0d errors", id, name, errors - errStart);
   endtask

   initial begin
      rngState   = 32'hab20_3b08;
      checks     = 0;
      errors     = 0;
      arstN      = 1'b0;
      stall      = 1'b0;
      flush      = 1'b0;
      instrValid = 1'b0;
      instr      = `NOP_INSTR;
      wbRegWrt   = 1'b0;
      wbReg      = '0;
      wbData     = '0;
      ifIdInstr  = `NOP_INSTR;  // IF/ID resets to an invalid nop
      ifIdValid  = 1'b0;
      idExExp    = '0;
      for (int r = 0; r < `REG_CNT; r++) shadowRegs[r] = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      #2 arstN = 1'b1;
      compareOutputs();  // reset values at the ex outputs
      for (int r = 0; r < `REG_CNT; r++) begin
         wbRegWrt = 1'b1;
         wbReg    = 3'(r);
         wbData   = 16'(nextRand() >> 7);
         stepCycle();
      end
      opPool = '{opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli, opBtr,
                 opShiftReg, opAluReg, opSeq, opSlt, opSle, opSco, opLbi, opSlbi};
      runTest(1, "immediate and register alu", 95, 0, 0, 0);
      opPool = '{opSt, opLd, opStu};
      runTest(2, "load, store and stu", 95, 0, 0, 0);
      opPool = '{opBeqz, opBnez, opBltz, opBgez, opJ, opJr, opJal, opJalr};
      runTest(3, "branches and jumps", 95, 0, 0, 0);
      opPool.delete();
      for (int i = 0; i < 32; i++) opPool.push_back(5'(i));  // whole opcode space
      runTest(4, "bubbles from invalid and flush", 50, 40, 0, 0);
      opPool = '{opHalt, 5'b00010, 5'b00011, opNop, opAddi, opStu};
      runTest(5, "illegal opcodes and halt", 95, 0, 0, 0);
      opPool.delete();
      for (int i = 0; i < 32; i++) opPool.push_back(5'(i));
      runTest(6, "stall and write timing", 90, 10, 35, 60);
      instrValid = 1'b0;  // drain the last two slots
      stall      = 1'b0;
      flush      = 1'b0;
      wbRegWrt   = 1'b0;
      repeat (2) stepCycle();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* verilog/decodeTop.sv */
`timescale 1ns/100ps
`include "decode_macros.svh"

module decodeTop import decodePkg::*; (
   input  logic                  clk,
   input  logic                  arstN,
   input  logic                  stall,       // freeze both pipeline registers
   input  logic                  flush,
   input  logic                  instrValid,
   input  logic [`DATA_W-1:0]    instr,
   input  logic [`DATA_W-1:0]    wbData,
   input  logic                  wbRegWrt,
   input  logic [`REG_SEL_W-1:0] wbReg,
   output logic [`DATA_W-1:0]    exInA, exInB, exWrtData, exImm8, exImm11,
   output aluOpT                 exAluOp,
   output logic [`REG_SEL_W-1:0] exWrtReg,
   output logic                  exRegWrt, exMemWrt, exReadEn,
   output brchT                  exBrchSig,
   output wbSelT                 exWbDataSel,
   output logic                  exImmSrc, exAluJmp, exJalSel,
   output logic                  exCreateDump, exErr, exJumpInst
);

   // IF/ID comes out of reset holding an invalid nop
   localparam ifIdT ifIdRst = '{instr: `NOP_INSTR, valid: 1'b0};
   localparam idExT idExRst = '0;

   ifIdT ifIdD, ifIdQ;
   idExT idExD, idExQ;

   assign ifIdD = '{instr: instr, valid: instrValid};

   pipeReg #(.payloadT(ifIdT), .resetVal(ifIdRst)) ifIdReg (
      .clk(clk), .arstN(arstN), .stall(stall), .d(ifIdD), .q(ifIdQ)
   );

   decode i_decode (
      .clk(clk), .arstN(arstN), .flush(flush), .ifId(ifIdQ),
      .wbRegWrt(wbRegWrt), .wbReg(wbReg), .wbData(wbData), .idEx(idExD)
   );

   pipeReg #(.payloadT(idExT), .resetVal(idExRst)) idExReg (
      .clk(clk), .arstN(arstN), .stall(stall), .d(idExD), .q(idExQ)
   );

   assign {exAluOp, exInA, exInB, exWrtData, exImm8, exImm11} =
      {idExQ.aluOp, idExQ.inA, idExQ.inB, idExQ.wrtData, idExQ.imm8, idExQ.imm11};
   assign {exWrtReg, exRegWrt, exMemWrt, exReadEn} =
      {idExQ.wrtReg, idExQ.regWrt, idExQ.memWrt, idExQ.readEn};
   assign exBrchSig    = idExQ.brchSig;
   assign exWbDataSel  = idExQ.wbDataSel;
   assign {exImmSrc, exAluJmp, exJalSel} = {idExQ.immSrc, idExQ.aluJmp, idExQ.jalSel};
   assign {exCreateDump, exErr, exJumpInst} =
      {idExQ.createDump, idExQ.err, idExQ.jumpInst};

endmodule

/* verilog/decode.sv */
`timescale 1ns/100ps
`include "decode_macros.svh"

module decode import decodePkg::*; (
   input  logic                  clk,
   input  logic                  arstN,
   input  logic                  flush,     // squash the instruction in decode
   input  ifIdT                  ifId,
   input  logic                  wbRegWrt,
   input  logic [`REG_SEL_W-1:0] wbReg,
   input  logic [`DATA_W-1:0]    wbData,
   output idExT                  idEx
);

   ctrlIf ctrlBus ();

   logic [`DATA_W-1:0]    inst;  // instruction after bubble insertion
   logic [`DATA_W-1:0]    imm5, imm8, imm11;
   logic [`DATA_W-1:0]    regA, regB, inB;
   logic [`REG_SEL_W-1:0] wrtReg;
   aluOpT                 aluOp;

   // invalid or flushed slot decodes as nop
   assign inst = (ifId.valid && !flush) ? ifId.instr : `NOP_INSTR;

   controlUnit i_controlUnit (.instruction(inst), .ctrl(ctrlBus.ctrl));
   aluOpDecode i_aluOpDecode (.instruction(inst), .aluOp(aluOp));

   regFile i_regFile (
      .clk(clk), .arstN(arstN),
      .rdSelA(inst[10:8]), .rdSelB(inst[7:5]),
      .wrEn(wbRegWrt), .wrSel(wbReg), .wrData(wbData),
      .rdDataA(regA), .rdDataB(regB)
   );

   assign imm5  = ctrlBus.zeroSel ? {{(`DATA_W-5){1'b0}}, inst[4:0]}
                                  : {{(`DATA_W-5){inst[4]}}, inst[4:0]};
   assign imm8  = ctrlBus.zeroSel ? {{(`DATA_W-8){1'b0}}, inst[7:0]}
                                  : {{(`DATA_W-8){inst[7]}}, inst[7:0]};
   assign imm11 = {{(`DATA_W-11){inst[10]}}, inst[10:0]};  // always signed

   always_comb begin
      case (ctrlBus.bSrc)
         bSrcImm5:  inB = imm5;
         bSrcImm8:  inB = imm8;
         bSrcImm11: inB = imm11;
         default:   inB = regB;
      endcase
      case (ctrlBus.regDestSel)
         destHi:  wrtReg = inst[10:8];
         destMid: wrtReg = inst[7:5];
         destLo:  wrtReg = inst[4:2];
         default: wrtReg = `LINK_REG;
      endcase
   end

   always_comb begin
      idEx.aluOp      = aluOp;
      idEx.inA        = regA;
      idEx.inB        = inB;
      idEx.wrtData    = ctrlBus.stuSel ? regB : inB;  // store data
      idEx.imm8       = imm8;
      idEx.imm11      = imm11;
      idEx.wrtReg     = wrtReg;
      idEx.regWrt     = ctrlBus.regWrt;
      idEx.memWrt     = ctrlBus.memWrt;
      idEx.readEn     = (ctrlBus.wbDataSel == wbMem);  // loads only
      idEx.brchSig    = ctrlBus.brchSig;
      idEx.wbDataSel  = ctrlBus.wbDataSel;
      idEx.immSrc     = ctrlBus.immSrc;
      idEx.aluJmp     = ctrlBus.aluJmp;
      idEx.jalSel     = ctrlBus.jalSel;
      idEx.createDump = ctrlBus.createDump;
      idEx.err        = ctrlBus.err;
      idEx.jumpInst   = (inst[15:13] == 3'b001);  // j, jr, jal, jalr
   end

endmodule

/* verilog/pipeReg.sv */
`timescale 1ns/100ps

// generic pipeline register, holds while stall is high
module pipeReg #(
   parameter type     payloadT = logic,
   parameter payloadT resetVal = '0
) (
   input  logic    clk,
   input  logic    arstN,
   input  logic    stall,
   input  payloadT d,
   output payloadT q
);

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         q <= resetVal;
      end else if (!stall) begin
         q <= d;
      end
   end

endmodule

/* verilog/regFile.sv */
`timescale 1ns/100ps
`include "decode_macros.svh"

// 2 read, 1 write register file, reads see the pre-write value
module regFile (
   input  logic                  clk,
   input  logic                  arstN,
   input  logic [`REG_SEL_W-1:0] rdSelA,
   input  logic [`REG_SEL_W-1:0] rdSelB,
   input  logic                  wrEn,
   input  logic [`REG_SEL_W-1:0] wrSel,
   input  logic [`DATA_W-1:0]    wrData,
   output logic [`DATA_W-1:0]    rdDataA,
   output logic [`DATA_W-1:0]    rdDataB
);

   logic [`DATA_W-1:0] regs [`REG_CNT];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < `REG_CNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrSel] <= wrData;
      end
   end

   // no bypass from the write port
   assign rdDataA = regs[rdSelA];
   assign rdDataB = regs[rdSelB];

endmodule

/* verilog/aluOpDecode.sv */
`timescale 1ns/100ps
`include "decode_macros.svh"

module aluOpDecode import decodePkg::*; (
   input  logic [`DATA_W-1:0] instruction,
   output aluOpT              aluOp
);

   opcodeT     opcode;
   logic [1:0] func;  // R format function bits

   assign opcode = opcodeT'(instruction[`OPC_HI:`OPC_LO]);
   assign func   = instruction[1:0];

   always_comb begin
      case (opcode)
         // address and jump target arithmetic
         opAddi, opSt, opLd, opStu, opJr, opJalr: aluOp = aluAdd;
         opSubi:  aluOp = aluSub;
         opXori:  aluOp = aluXor;
         opAndni: aluOp = aluAndn;
         opRoli:  aluOp = aluRol;
         opSlli:  aluOp = aluSll;
         opRori:  aluOp = aluRor;
         opSrli:  aluOp = aluSrl;
         // func indexes straight into each group of four
         opAluReg:   aluOp = aluOpT'({2'b00, func});
         opShiftReg: aluOp = aluOpT'({2'b01, func});
         opSeq: aluOp = aluSeq;
         opSlt: aluOp = aluSlt;
         opSle: aluOp = aluSle;
         opSco: aluOp = aluSco;
         opBtr: aluOp = aluBtr;
         opLbi, opBeqz, opBnez, opBltz, opBgez: aluOp = aluPassB;
         opSlbi: aluOp = aluSlbi;
         default: aluOp = aluAdd;  // halt, nop, j, jal, illegal
      endcase
   end

endmodule

/* verilog/controlUnit.sv */
`timescale 1ns/100ps
`include "decode_macros.svh"

module controlUnit import decodePkg::*; (
   input logic [`DATA_W-1:0] instruction,
   ctrlIf.ctrl               ctrl
);

   opcodeT opcode;

   assign opcode = opcodeT'(instruction[`OPC_HI:`OPC_LO]);

   always_comb begin
      // defaults are the NOP decode
      ctrl.bSrc       = bSrcReg;
      ctrl.zeroSel    = 1'b0;
      ctrl.regDestSel = destLo;
      ctrl.stuSel     = 1'b0;
      ctrl.regWrt     = 1'b0;
      ctrl.memWrt     = 1'b0;
      ctrl.wbDataSel  = wbAlu;
      ctrl.brchSig    = brNone;
      ctrl.immSrc     = 1'b0;
      ctrl.aluJmp     = 1'b0;
      ctrl.jalSel     = 1'b0;
      ctrl.createDump = 1'b0;
      ctrl.err        = 1'b0;
      case (opcode)
         opHalt: ctrl.createDump = 1'b1;
         opNop: ctrl.regWrt = 1'b0;  // bubble, nothing enabled
         // rd <- rs op imm5, signed immediate
         opAddi, opSubi: begin
            ctrl.bSrc       = bSrcImm5;
            ctrl.regDestSel = destMid;
            ctrl.regWrt     = 1'b1;
         end
         // logic and shift immediates are unsigned
         opXori, opAndni, opRoli, opSlli, opRori, opSrli: begin
            ctrl.bSrc       = bSrcImm5;
            ctrl.zeroSel    = 1'b1;
            ctrl.regDestSel = destMid;
            ctrl.regWrt     = 1'b1;
         end
         opSt: begin
            ctrl.bSrc   = bSrcImm5;  // address = rs + imm5
            ctrl.stuSel = 1'b1;      // data is rd from read port B
            ctrl.memWrt = 1'b1;
         end
         opLd: begin
            ctrl.bSrc       = bSrcImm5;
            ctrl.regDestSel = destMid;
            ctrl.regWrt     = 1'b1;
            ctrl.wbDataSel  = wbMem;
         end
         opStu: begin
            ctrl.bSrc       = bSrcImm5;
            ctrl.stuSel     = 1'b1;
            ctrl.memWrt     = 1'b1;
            ctrl.regDestSel = destHi;  // rs gets the updated address
            ctrl.regWrt     = 1'b1;
         end
         // R format, result into bits 4:2
         opBtr, opAluReg, opShiftReg, opSeq, opSlt, opSle, opSco: begin
            ctrl.regDestSel = destLo;
            ctrl.regWrt     = 1'b1;
         end
         opBeqz: ctrl.brchSig = brEqz;
         opBnez: ctrl.brchSig = brNez;
         opBltz: ctrl.brchSig = brLtz;
         opBgez: ctrl.brchSig = brGez;
         opLbi: begin
            ctrl.bSrc       = bSrcImm8;  // sign extended
            ctrl.regDestSel = destHi;
            ctrl.regWrt     = 1'b1;
         end
         opSlbi: begin
            ctrl.bSrc       = bSrcImm8;
            ctrl.zeroSel    = 1'b1;
            ctrl.regDestSel = destHi;
            ctrl.regWrt     = 1'b1;
         end
         opJ: ctrl.immSrc = 1'b1;  // pc + 2 + imm11
         opJal: begin
            ctrl.immSrc     = 1'b1;
            ctrl.jalSel     = 1'b1;
            ctrl.regDestSel = destLink;
            ctrl.regWrt     = 1'b1;
            ctrl.wbDataSel  = wbPc2;
         end
         opJr: begin
            ctrl.bSrc   = bSrcImm8;  // target = rs + imm8
            ctrl.aluJmp = 1'b1;
         end
         opJalr: begin
            ctrl.bSrc       = bSrcImm8;
            ctrl.aluJmp     = 1'b1;
            ctrl.jalSel     = 1'b1;
            ctrl.regDestSel = destLink;
            ctrl.regWrt     = 1'b1;
            ctrl.wbDataSel  = wbPc2;
         end
         default: ctrl.err = 1'b1;  // no write of any kind
      endcase
   end

endmodule

/* verilog/ctrlIf.sv */
`timescale 1ns/100ps

// control bundle from the opcode table into the decode datapath
interface ctrlIf import decodePkg::*; ();
   bSrcT    bSrc;        // alu B operand source
   logic    zeroSel;     // zero extend imm5/imm8 when set
   regDestT regDestSel;  // destination register field
   logic    stuSel;      // store data from second read port
   logic    regWrt;
   logic    memWrt;
   wbSelT   wbDataSel;
   brchT    brchSig;
   logic    immSrc;      // pc offset is imm11 when set, else imm8
   logic    aluJmp;      // jump target comes from the alu (jr, jalr)
   logic    jalSel;      // link write for jal/jalr
   logic    createDump;  // halt
   logic    err;         // illegal opcode

   modport ctrl (
      output bSrc, zeroSel, regDestSel, stuSel,
      output regWrt, memWrt, wbDataSel, brchSig,
      output immSrc, aluJmp, jalSel, createDump, err
   );

   modport dec (
      input bSrc, zeroSel, regDestSel, stuSel,
      input regWrt, memWrt, wbDataSel, brchSig,
      input immSrc, aluJmp, jalSel, createDump, err
   );
endinterface

/* verilog/decodePkg.sv */
`include "decode_macros.svh"

package decodePkg;

   // opcode field, bits 15:11
   typedef enum logic [4:0] {
      opHalt     = 5'b00000,
      opNop      = 5'b00001,
      opJ        = 5'b00100,
      opJr       = 5'b00101,
      opJal      = 5'b00110,
      opJalr     = 5'b00111,
      opAddi     = 5'b01000,
      opSubi     = 5'b01001,
      opXori     = 5'b01010,
      opAndni    = 5'b01011,
      opBeqz     = 5'b01100,
      opBnez     = 5'b01101,
      opBltz     = 5'b01110,
      opBgez     = 5'b01111,
      opSt       = 5'b10000,
      opLd       = 5'b10001,
      opSlbi     = 5'b10010,
      opStu      = 5'b10011,
      opRoli     = 5'b10100,
      opSlli     = 5'b10101,
      opRori     = 5'b10110,
      opSrli     = 5'b10111,
      opLbi      = 5'b11000,
      opBtr      = 5'b11001,
      opShiftReg = 5'b11010, // rol/sll/ror/srl by func bits
      opAluReg   = 5'b11011, // add/sub/xor/andn by func bits
      opSeq      = 5'b11100,
      opSlt      = 5'b11101,
      opSle      = 5'b11110,
      opSco      = 5'b11111
   } opcodeT;

   // add must stay at 0, it is the reset value at the ex outputs
   typedef enum logic [3:0] {
      aluAdd, aluSub, aluXor, aluAndn,  // func 00..11 of the arith group
      aluRol, aluSll, aluRor, aluSrl,   // func 00..11 of the shift group
      aluSeq, aluSlt, aluSle, aluSco,
      aluBtr, aluPassB, aluSlbi
   } aluOpT;

   typedef enum logic [1:0] {bSrcReg, bSrcImm5, bSrcImm8, bSrcImm11} bSrcT;
   typedef enum logic [1:0] {destHi, destMid, destLo, destLink} regDestT; // 10:8, 7:5, 4:2, r7
   typedef enum logic [1:0] {wbAlu, wbMem, wbPc2} wbSelT;
   typedef enum logic [2:0] {brNone, brEqz, brNez, brLtz, brGez} brchT;

   typedef struct packed {
      logic [`DATA_W-1:0] instr;
      logic               valid;
   } ifIdT;

   typedef struct packed {
      aluOpT                aluOp;
      logic [`DATA_W-1:0]   inA, inB, wrtData, imm8, imm11;
      logic [`REG_SEL_W-1:0] wrtReg;
      logic                 regWrt, memWrt, readEn;
      brchT                 brchSig;
      wbSelT                wbDataSel;
      logic                 immSrc, aluJmp, jalSel;
      logic                 createDump, err, jumpInst;
   } idExT;

endpackage

/* include/decode_macros.svh */
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// datapath and instruction width
`define DATA_W 16

// register file geometry
`define REG_CNT 8
`define REG_SEL_W 3

// bubble word, opcode 00001 with all fields zero
`define NOP_INSTR 16'h0800

// instruction field positions
`define OPC_HI 15
`define OPC_LO 11

// link register used by jal and jalr
`define LINK_REG 3'd7

`endif
